// ==== compile.f ====
hw/cache_geom_pkg.sv
hw/mem_bus_pkg.sv
hw/dcache_way.sv
hw/dcache_ctrl.sv
hw/dcache.sv
dv/tb_ram.sv
dv/tb_dcache.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the data cache testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f compile.f \
  --top-module tb_dcache \
  -Mdir obj_dir \
  -o sim_tb_dcache
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb_dcache 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
  exit 0
fi
echo "pass message not found"
exit 1

// ==== dv/tb_dcache.sv ====
module tb_dcache;
  import cache_geom_pkg::*;
  import mem_bus_pkg::*;

  localparam int PERIOD    = 4;
  localparam int N_REQ     = 17;                         // requests over all scenarios
  localparam int MISS_CYC  = 2 * WORDS_PER_LINE * 4 + 2; // wb + fill, 4 cycles each worst
  localparam int FLUSH_CYC = DEF_SETS * 4 * 4 + 4 + 8;   // every word dirty, count, tail
  localparam int TIMEOUT   = 2 * PERIOD * (N_REQ * MISS_CYC + FLUSH_CYC + 2);
  localparam logic [11:0] HIT_WORD = HIT_COUNT_ADDR[13:2];

  logic  CLK = 1'b0;
  logic  nRST, dmemREN, dmemWEN, halt;
  word_t dmemaddr, dmemstore;
  logic  dhit, flushed, dREN, dWEN, dwait;
  word_t dmemload, daddr, dstore, dload;

  // reference model
  word_t       model_mem [4096];                 // value the processor should see
  logic        line_dirty [2048];                // written since last writeback
  logic [25:0] mtag [8][2];
  logic        mvalid [8][2];
  logic        mlru [8];                         // 1 -> way1 is next victim
  word_t       exp_hits = '0;
  logic        exp_hit, first_cycle;
  word_t       cur_addr;
  logic        mem_wr, cnt_wr;
  int          errors = 0;                       // from concurrent checks
  int          end_errors = 0;                   // from end of run checks
  int          tests = 0;

  always #(PERIOD / 2) CLK = ~CLK;

  dcache #(.SETS(8)) uut (
    .CLK(CLK), .nRST(nRST), .dmemREN(dmemREN), .dmemWEN(dmemWEN), .dmemaddr(dmemaddr),
    .dmemstore(dmemstore), .halt(halt), .dhit(dhit), .dmemload(dmemload),
    .flushed(flushed), .dREN(dREN), .dWEN(dWEN), .daddr(daddr), .dstore(dstore),
    .dload(dload), .dwait(dwait)
  );

  tb_ram ram (
    .CLK(CLK), .nRST(nRST), .dREN(dREN), .dWEN(dWEN), .daddr(daddr),
    .dstore(dstore), .dload(dload), .dwait(dwait)
  );

  assign mem_wr = dWEN && !dwait && (daddr != HIT_COUNT_ADDR);
  assign cnt_wr = dWEN && !dwait && (daddr == HIT_COUNT_ADDR);

  // word values and dirty lines follow the handshakes
  always @(posedge CLK) begin
    if (!nRST) begin
      for (logic [12:0] i = 13'd0; i < 13'd4096; i++) begin
        model_mem[i[11:0]] <= {18'd0, i[11:0], 2'b00};
        line_dirty[i[11:1]] <= 1'b0;
      end
    end else begin
      if (dhit && dmemWEN) begin
        model_mem[dmemaddr[13:2]] <= dmemstore;
        line_dirty[dmemaddr[13:3]] <= 1'b1;
      end
      if (mem_wr && daddr[2]) line_dirty[daddr[13:3]] <= 1'b0;  // high word ends the line
    end
  end

  a_load: assert property (@(posedge CLK) disable iff (!nRST)
    dhit && dmemREN |-> dmemload == model_mem[dmemaddr[13:2]])
    else begin
      $display("FAIL t=%0t dmemload expected %h got %h", $time,
               $sampled(model_mem[dmemaddr[13:2]]), $sampled(dmemload));
      errors = errors + 1;
    end
  a_first: assert property (@(posedge CLK) disable iff (!nRST)
    first_cycle |-> dhit == exp_hit)
    else begin
      $display("FAIL t=%0t dhit expected %b got %b", $time, $sampled(exp_hit), $sampled(dhit));
      errors = errors + 1;
    end
  a_fetch: assert property (@(posedge CLK) disable iff (!nRST)
    dREN |-> daddr[31:3] == cur_addr[31:3])
    else begin
      $display("FAIL t=%0t daddr expected line %h got %h", $time,
               {$sampled(cur_addr[31:3]), 3'b000}, $sampled(daddr));
      errors = errors + 1;
    end
  a_wdata: assert property (@(posedge CLK) disable iff (!nRST)
    mem_wr |-> dstore == model_mem[daddr[13:2]])
    else begin
      $display("FAIL t=%0t dstore expected %h got %h", $time,
               $sampled(model_mem[daddr[13:2]]), $sampled(dstore));
      errors = errors + 1;
    end
  a_clean: assert property (@(posedge CLK) disable iff (!nRST)
    mem_wr |-> line_dirty[daddr[13:3]])
    else begin
      $display("t=%0t memory write to a clean line at %h", $time, $sampled(daddr));
      errors = errors + 1;
    end
  a_count: assert property (@(posedge CLK) disable iff (!nRST)
    cnt_wr |-> dstore == exp_hits)
    else begin
      $display("FAIL t=%0t dstore expected %h got %h", $time, $sampled(exp_hits), $sampled(dstore));
      errors = errors + 1;
    end
  a_quiet: assert property (@(posedge CLK) disable iff (!nRST)
    flushed |-> !dWEN && !dREN)
    else begin
      $display("t=%0t memory request after the flush finished", $time);
      errors = errors + 1;
    end
  a_sticky: assert property (@(posedge CLK) disable iff (!nRST)
    flushed |=> flushed)
    else begin
      $display("FAIL t=%0t flushed expected 1 got %b", $time, $sampled(flushed));
      errors = errors + 1;
    end

  function automatic word_t make_addr(input logic [7:0] tag, input logic [2:0] set,
                                      input logic w);
    return {18'd0, tag, set, w, 2'b00};
  endfunction

  // two way lru lookup, fills the victim on a miss
  function automatic logic predict_hit(input word_t addr);
    logic [2:0]  s;
    logic [25:0] t;
    logic        v;
    s = addr[5:3];
    t = addr[31:6];
    if (mvalid[s][0] && mtag[s][0] == t) begin
      mlru[s] = 1'b1;
      return 1'b1;
    end
    if (mvalid[s][1] && mtag[s][1] == t) begin
      mlru[s] = 1'b0;
      return 1'b1;
    end
    v = mlru[s];
    mvalid[s][v] = 1'b1;
    mtag[s][v] = t;
    mlru[s] = !v;
    return 1'b0;
  endfunction

  // one request, held until dhit
  task automatic access(input logic wr, input word_t addr, input word_t wdat);
    logic done;
    exp_hit = predict_hit(addr);
    if (exp_hit) exp_hits = exp_hits + 1;
    cur_addr = addr;
    dmemaddr = addr;
    dmemstore = wdat;
    dmemREN = !wr;
    dmemWEN = wr;
    first_cycle = 1'b1;
    @(negedge CLK);
    done = dhit;
    @(posedge CLK);
    #1 first_cycle = 1'b0;
    while (!done) begin
      @(negedge CLK);
      done = dhit;                               // stable mid cycle
      @(posedge CLK);
      #1;
    end
    dmemREN = 1'b0;
    dmemWEN = 1'b0;
  endtask

  task automatic test_done(input string name, input int start);
    tests = tests + 1;
    $display("test %0d %s: %0d errors", tests, name, errors + end_errors - start);
  endtask

  initial begin
    int start;
    nRST = 1'b0;
    dmemREN = 1'b0;
    dmemWEN = 1'b0;
    halt = 1'b0;
    dmemaddr = '0;
    dmemstore = '0;
    exp_hit = 1'b0;
    first_cycle = 1'b0;
    cur_addr = '0;
    for (int s = 0; s < 8; s++) begin
      mvalid[s][0] = 1'b0;
      mvalid[s][1] = 1'b0;
      mlru[s] = 1'b0;
    end
    repeat (2) @(posedge CLK);
    #1 nRST = 1'b1;

    start = errors + end_errors;
    access(1'b0, make_addr(8'd1, 3'd0, 1'b0), '0);        // cold miss
    access(1'b0, make_addr(8'd1, 3'd0, 1'b0), '0);
    access(1'b0, make_addr(8'd1, 3'd0, 1'b1), '0);
    test_done("read miss then hit", start);

    start = errors + end_errors;
    access(1'b1, make_addr(8'd1, 3'd0, 1'b0), 32'hcafe_0001);
    access(1'b0, make_addr(8'd1, 3'd0, 1'b0), '0);
    access(1'b0, make_addr(8'd1, 3'd0, 1'b1), '0);        // neighbor untouched
    access(1'b1, make_addr(8'd2, 3'd1, 1'b1), 32'hcafe_0002);  // write miss
    test_done("write hit", start);

    start = errors + end_errors;
    access(1'b1, make_addr(8'd3, 3'd2, 1'b0), 32'hbeef_0003);
    access(1'b1, make_addr(8'd4, 3'd2, 1'b1), 32'hbeef_0004);
    access(1'b1, make_addr(8'd5, 3'd2, 1'b0), 32'hbeef_0005);  // tag 3 goes out
    access(1'b0, make_addr(8'd3, 3'd2, 1'b0), '0);             // tag 4 goes out
    test_done("dirty eviction", start);

    start = errors + end_errors;
    access(1'b0, make_addr(8'd6, 3'd3, 1'b0), '0);        // a
    access(1'b0, make_addr(8'd7, 3'd3, 1'b0), '0);        // b
    access(1'b0, make_addr(8'd6, 3'd3, 1'b1), '0);        // a again
    access(1'b0, make_addr(8'd8, 3'd3, 1'b0), '0);        // c replaces b
    access(1'b0, make_addr(8'd6, 3'd3, 1'b0), '0);
    access(1'b0, make_addr(8'd7, 3'd3, 1'b0), '0);        // b refetched
    test_done("lru", start);

    start = errors + end_errors;
    halt = 1'b1;
    while (!flushed) @(negedge CLK);
    repeat (4) @(posedge CLK);                   // flushed must hold
    #1;
    for (logic [12:0] i = 13'd0; i < 13'd4096; i++) begin
      if (i[11:0] == HIT_WORD) begin
        assert (ram.mem[i[11:0]] == exp_hits) else begin
          $display("FAIL t=%0t hit count expected %h got %h", $time, exp_hits,
                   ram.mem[i[11:0]]);
          end_errors = end_errors + 1;
        end
      end else begin
        assert (ram.mem[i[11:0]] == model_mem[i[11:0]]) else begin
          $display("FAIL t=%0t mem[%h] expected %h got %h", $time, {i[11:0], 2'b00},
                   model_mem[i[11:0]], ram.mem[i[11:0]]);
          end_errors = end_errors + 1;
        end
      end
    end
    test_done("halt flush", start);

    $display("%0d tests, %0d requests, %0d errors", tests, N_REQ, errors + end_errors);
    if (errors + end_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // watchdog sized from worst case miss and flush lengths
  initial begin
    #(TIMEOUT);
    $display("timeout: run did not finish within %0d time units", TIMEOUT);
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== dv/tb_ram.sv ====
// behavioral word memory on the cache's memory side
// every word starts out holding its own byte address
// each transfer is held off by 0 to 3 cycles of dwait, drawn from an lcg
module tb_ram #(
  parameter logic [31:0] SEED = 32'h4d9d843d
) (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               dREN,
  input  logic               dWEN,
  input  mem_bus_pkg::word_t daddr,
  input  mem_bus_pkg::word_t dstore,
  output mem_bus_pkg::word_t dload,
  output logic               dwait
);
  import mem_bus_pkg::*;

  word_t       mem [4096];                    // 16 kB window, covers the count address
  logic [31:0] lcg, lcg_nxt;
  logic [1:0]  lat;                           // wait cycles for the current transfer
  logic [1:0]  cnt;                           // wait cycles spent so far

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;  // numerical recipes constants
  endfunction

  assign lcg_nxt = lcg_step(lcg);
  assign dwait   = (dREN | dWEN) && (cnt != lat);
  assign dload   = mem[daddr[13:2]];          // valid in the !dwait cycle

  // memory contents and latency draw, loaded while reset is held
  always @(posedge CLK) begin
    if (!nRST) begin
      for (logic [12:0] i = 13'd0; i < 13'd4096; i++) begin
        mem[i[11:0]] <= {18'd0, i[11:0], 2'b00};
      end
      lcg <= SEED;
      lat <= SEED[17:16];
      cnt <= 2'd0;
    end else if ((dREN | dWEN) && !dwait) begin
      if (dWEN) mem[daddr[13:2]] <= dstore;   // transfer completes here
      lcg <= lcg_nxt;
      lat <= lcg_nxt[17:16];                  // upper bits, low ones repeat fast
      cnt <= 2'd0;
    end else if (dREN | dWEN) begin
      cnt <= cnt + 2'd1;
    end
  end

endmodule

// ==== hw/dcache.sv ====
// two way write-back data cache, top level
// two identical ways side by side, controller merges their results
module dcache #(
  parameter int SETS = cache_geom_pkg::DEF_SETS
) (
  input  logic               CLK,
  input  logic               nRST,
  // processor side
  input  logic               dmemREN,
  input  logic               dmemWEN,
  input  mem_bus_pkg::word_t dmemaddr,
  input  mem_bus_pkg::word_t dmemstore,
  input  logic               halt,
  output logic               dhit,
  output mem_bus_pkg::word_t dmemload,
  output logic               flushed,
  // memory side
  output logic               dREN,
  output logic               dWEN,
  output mem_bus_pkg::word_t daddr,
  output mem_bus_pkg::word_t dstore,
  input  mem_bus_pkg::word_t dload,
  input  logic               dwait
);
  import cache_geom_pkg::*;
  import mem_bus_pkg::*;

  localparam int IDX_W = index_bits(SETS);
  localparam int TAG_W = ADDR_W - IDX_W - WORD_SEL_W - BYTE_OFF_W;

  // shared write port, driven by the controller
  logic [IDX_W-1:0]      way_index;
  logic [TAG_W-1:0]      way_tag;
  logic                  we0, we1;
  logic [WORD_SEL_W-1:0] word_sel;
  word_t                 wdata;
  logic                  wvalid, wdirty;

  // per way results
  logic             hit0, hit1;
  logic [TAG_W-1:0] tag0, tag1;
  word_t            w0_word0, w0_word1, w1_word0, w1_word1;
  logic             valid0, valid1, dirty0, dirty1;

  dcache_way #(.SETS(SETS)) way0 (
    .CLK(CLK), .nRST(nRST), .index(way_index), .tag(way_tag), .we(we0),
    .word_sel(word_sel), .wdata(wdata), .wvalid(wvalid), .wdirty(wdirty),
    .hit(hit0), .line_tag(tag0), .line_word0(w0_word0), .line_word1(w0_word1),
    .line_valid(valid0), .line_dirty(dirty0)
  );

  dcache_way #(.SETS(SETS)) way1 (
    .CLK(CLK), .nRST(nRST), .index(way_index), .tag(way_tag), .we(we1),
    .word_sel(word_sel), .wdata(wdata), .wvalid(wvalid), .wdirty(wdirty),
    .hit(hit1), .line_tag(tag1), .line_word0(w1_word0), .line_word1(w1_word1),
    .line_valid(valid1), .line_dirty(dirty1)
  );

  dcache_ctrl #(.SETS(SETS)) ctrl (
    .CLK(CLK), .nRST(nRST),
    .dmemREN(dmemREN), .dmemWEN(dmemWEN), .dmemaddr(dmemaddr), .dmemstore(dmemstore),
    .halt(halt), .dhit(dhit), .dmemload(dmemload), .flushed(flushed),
    .dload(dload), .dwait(dwait), .dREN(dREN), .dWEN(dWEN), .daddr(daddr), .dstore(dstore),
    .hit0(hit0), .hit1(hit1),
    .way0_tag(tag0), .way0_word0(w0_word0), .way0_word1(w0_word1),
    .way0_valid(valid0), .way0_dirty(dirty0),
    .way1_tag(tag1), .way1_word0(w1_word0), .way1_word1(w1_word1),
    .way1_valid(valid1), .way1_dirty(dirty1),
    .way_index(way_index), .way_tag(way_tag), .we0(we0), .we1(we1),
    .word_sel(word_sel), .wdata(wdata), .wvalid(wvalid), .wdirty(wdirty)
  );

endmodule

// ==== hw/dcache_ctrl.sv ====
// controller of the two way data cache
// hit detection, lru, miss fill, dirty writeback, halt flush and hit count store
module dcache_ctrl #(
  parameter int SETS = cache_geom_pkg::DEF_SETS,
  localparam int IDX_W = cache_geom_pkg::index_bits(SETS),
  localparam int TAG_W = cache_geom_pkg::ADDR_W - IDX_W - cache_geom_pkg::WORD_SEL_W
                         - cache_geom_pkg::BYTE_OFF_W
) (
  input  logic                                  CLK,
  input  logic                                  nRST,
  // processor side
  input  logic                                  dmemREN,
  input  logic                                  dmemWEN,
  input  mem_bus_pkg::word_t                    dmemaddr,
  input  mem_bus_pkg::word_t                    dmemstore,
  input  logic                                  halt,
  output logic                                  dhit,
  output mem_bus_pkg::word_t                    dmemload,
  output logic                                  flushed,
  // memory side
  input  mem_bus_pkg::word_t                    dload,
  input  logic                                  dwait,
  output logic                                  dREN,
  output logic                                  dWEN,
  output mem_bus_pkg::word_t                    daddr,
  output mem_bus_pkg::word_t                    dstore,
  // results from the ways
  input  logic                                  hit0,
  input  logic                                  hit1,
  input  logic [TAG_W-1:0]                      way0_tag,
  input  mem_bus_pkg::word_t                    way0_word0,
  input  mem_bus_pkg::word_t                    way0_word1,
  input  logic                                  way0_valid,
  input  logic                                  way0_dirty,
  input  logic [TAG_W-1:0]                      way1_tag,
  input  mem_bus_pkg::word_t                    way1_word0,
  input  mem_bus_pkg::word_t                    way1_word1,
  input  logic                                  way1_valid,
  input  logic                                  way1_dirty,
  // shared way write port
  output logic [IDX_W-1:0]                      way_index,
  output logic [TAG_W-1:0]                      way_tag,
  output logic                                  we0,
  output logic                                  we1,
  output logic [cache_geom_pkg::WORD_SEL_W-1:0] word_sel,
  output mem_bus_pkg::word_t                    wdata,
  output logic                                  wvalid,
  output logic                                  wdirty
);
  import cache_geom_pkg::*;
  import mem_bus_pkg::*;

  typedef enum logic [3:0] {
    IDLE, FETCH1, FETCH2, WB1, WB2,
    FLUSH_W0L, FLUSH_W0H, FLUSH_W1L, FLUSH_W1H,
    STORE_COUNT, DONE
  } ctrl_state_e;

  localparam logic [WORD_SEL_W-1:0] SEL_LO = WORD_SEL_W'(0);
  localparam logic [WORD_SEL_W-1:0] SEL_HI = WORD_SEL_W'(1);
  localparam logic [BYTE_OFF_W-1:0] BYTE0  = '0;

  ctrl_state_e state, next_state, flush_next;

  // request decode
  logic [TAG_W-1:0]      rq_tag;
  logic [IDX_W-1:0]      rq_idx;
  logic [WORD_SEL_W-1:0] rq_sel;
  logic                  req;

  // victim line, picked by lru
  logic [SETS-1:0]  lru;                     // 1 -> way1 is the next victim
  logic             victim;
  logic [TAG_W-1:0] vic_tag;
  word_t            vic_word0, vic_word1;
  logic             vic_valid, vic_dirty;

  // flush walk
  logic [IDX_W-1:0] flush_idx;
  logic             flushing, fl_way, fl_word, fl_dirty, fl_step, last_set;
  logic [TAG_W-1:0] fl_tag;
  word_t            fl_data;

  logic  cache_we, tgt_way;
  logic  missed;                             // current request already missed once
  word_t hit_count;

  assign rq_tag = dmemaddr[ADDR_W-1 -: TAG_W];
  assign rq_idx = dmemaddr[BYTE_OFF_W+WORD_SEL_W +: IDX_W];
  assign rq_sel = dmemaddr[BYTE_OFF_W +: WORD_SEL_W];
  assign req    = dmemREN | dmemWEN;

  // hit only counts while idle, flush indexing would fake one
  assign dhit = (state == IDLE) && !halt && req && (hit0 | hit1);

  always_comb begin
    dmemload = '0;                           // miss loads zero
    if (dhit) begin
      if (hit1) begin
        dmemload = (rq_sel == SEL_LO) ? way1_word0 : way1_word1;
      end else begin
        dmemload = (rq_sel == SEL_LO) ? way0_word0 : way0_word1;
      end
    end
  end

  assign victim    = lru[rq_idx];
  assign vic_tag   = victim ? way1_tag   : way0_tag;
  assign vic_word0 = victim ? way1_word0 : way0_word0;
  assign vic_word1 = victim ? way1_word1 : way0_word1;
  assign vic_valid = victim ? way1_valid : way0_valid;
  assign vic_dirty = victim ? way1_dirty : way0_dirty;

  // flush order per set: way0 lo, way0 hi, way1 lo, way1 hi
  assign flushing = (state == FLUSH_W0L) || (state == FLUSH_W0H) ||
                    (state == FLUSH_W1L) || (state == FLUSH_W1H);
  assign fl_way   = (state == FLUSH_W1L) || (state == FLUSH_W1H);
  assign fl_word  = (state == FLUSH_W0H) || (state == FLUSH_W1H);
  assign fl_dirty = fl_way ? way1_dirty : way0_dirty;
  assign fl_tag   = fl_way ? way1_tag : way0_tag;
  assign fl_data  = fl_way ? (fl_word ? way1_word1 : way1_word0)
                           : (fl_word ? way0_word1 : way0_word0);
  assign fl_step  = flushing && (!fl_dirty || !dwait);   // clean word skips at once
  assign last_set = (flush_idx == IDX_W'(SETS - 1));

  always_comb begin
    case (state)
      FLUSH_W0L: flush_next = FLUSH_W0H;
      FLUSH_W0H: flush_next = FLUSH_W1L;
      FLUSH_W1L: flush_next = FLUSH_W1H;
      default:   flush_next = last_set ? STORE_COUNT : FLUSH_W0L;
    endcase
  end

  // ways see the flush set while flushing, else the request set
  assign way_index = flushing ? flush_idx : rq_idx;
  assign way_tag   = rq_tag;
  assign we0       = cache_we && !tgt_way;
  assign we1       = cache_we && tgt_way;
  assign flushed   = (state == DONE);

  // next state and memory drive
  always_comb begin
    next_state = state;
    dREN       = 1'b0;
    dWEN       = 1'b0;
    daddr      = '0;
    dstore     = '0;
    cache_we   = 1'b0;
    tgt_way    = victim;                     // fills go to the lru way
    word_sel   = rq_sel;
    wdata      = dmemstore;
    wvalid     = 1'b1;
    wdirty     = 1'b1;
    case (state)
      IDLE: begin
        if (halt) begin
          next_state = FLUSH_W0L;
        end else if (dhit) begin
          cache_we = dmemWEN;                // write hit marks the line dirty
          tgt_way  = hit1;
        end else if (req) begin
          next_state = (vic_valid && vic_dirty) ? WB1 : FETCH1;
        end
      end
      FETCH1, FETCH2: begin
        dREN     = 1'b1;
        word_sel = (state == FETCH2) ? SEL_HI : SEL_LO;
        daddr    = {rq_tag, rq_idx, word_sel, BYTE0};
        wdata    = dload;
        wvalid   = (state == FETCH2);        // valid only once both words are in
        wdirty   = 1'b0;
        if (!dwait) begin
          cache_we   = 1'b1;
          next_state = (state == FETCH2) ? IDLE : FETCH2;
        end
      end
      WB1: begin
        dWEN   = 1'b1;
        daddr  = {vic_tag, rq_idx, SEL_LO, BYTE0};
        dstore = vic_word0;
        if (!dwait) next_state = WB2;
      end
      WB2: begin
        dWEN   = 1'b1;
        daddr  = {vic_tag, rq_idx, SEL_HI, BYTE0};
        dstore = vic_word1;
        if (!dwait) next_state = FETCH1;   // old line is out, refill
      end
      FLUSH_W0L, FLUSH_W0H, FLUSH_W1L, FLUSH_W1H: begin
        dWEN   = fl_dirty;
        daddr  = {fl_tag, flush_idx, WORD_SEL_W'(fl_word), BYTE0};
        dstore = fl_data;
        if (fl_step) next_state = flush_next;
      end
      STORE_COUNT: begin
        dWEN   = 1'b1;
        daddr  = HIT_COUNT_ADDR;
        dstore = hit_count;
        if (!dwait) next_state = DONE;
      end
      default: begin
        next_state = DONE;                   // parked until reset
      end
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state     <= IDLE;
      lru       <= '0;
      flush_idx <= '0;
      missed    <= 1'b0;
      hit_count <= '0;
    end else begin
      state <= next_state;
      if (dhit) begin
        lru[rq_idx] <= !hit1;                // the other way becomes victim
      end else if ((state == FETCH2) && !dwait) begin
        lru[rq_idx] <= !victim;              // just filled, keep it
      end
      if (fl_step && (state == FLUSH_W1H) && !last_set) begin
        flush_idx <= flush_idx + 1'b1;
      end
      // first cycle hit -> counted, anything after a miss is not
      if (dhit) begin
        missed <= 1'b0;
        if (!missed) hit_count <= hit_count + 1'b1;
      end else if ((state == IDLE) && req && !halt) begin
        missed <= 1'b1;
      end
    end
  end

endmodule

// ==== hw/dcache_way.sv ====
// one way of the data cache
// per set: tag, valid, dirty and a two word line
// single write port shared by fill, write hit and nothing else
module dcache_way #(
  parameter int SETS = cache_geom_pkg::DEF_SETS,
  localparam int IDX_W = cache_geom_pkg::index_bits(SETS),
  localparam int TAG_W = cache_geom_pkg::ADDR_W - IDX_W - cache_geom_pkg::WORD_SEL_W
                         - cache_geom_pkg::BYTE_OFF_W
) (
  input  logic                                  CLK,
  input  logic                                  nRST,
  input  logic [IDX_W-1:0]                      index,      // request or flush set
  input  logic [TAG_W-1:0]                      tag,        // compare and write tag
  input  logic                                  we,         // write this way's set
  input  logic [cache_geom_pkg::WORD_SEL_W-1:0] word_sel,   // which word of the line
  input  mem_bus_pkg::word_t                    wdata,
  input  logic                                  wvalid,
  input  logic                                  wdirty,
  output logic                                  hit,
  output logic [TAG_W-1:0]                      line_tag,
  output mem_bus_pkg::word_t                    line_word0,
  output mem_bus_pkg::word_t                    line_word1,
  output logic                                  line_valid,
  output logic                                  line_dirty
);
  import mem_bus_pkg::*;

  // storage arrays
  logic [TAG_W-1:0] tags [SETS];
  word_t            data [SETS][WORDS_PER_LINE];
  logic [SETS-1:0]  valid;                   // cleared on reset, all lines invalid
  logic [SETS-1:0]  dirty;

  // state bits of the line
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid <= '0;
      dirty <= '0;
    end else if (we) begin
      valid[index] <= wvalid;                // fill clears then sets valid
      dirty[index] <= wdirty;                // write hit sets, fill clears
    end
  end

  // tag and data payload
  always_ff @(posedge CLK) begin
    if (we) begin
      tags[index]           <= tag;
      data[index][word_sel] <= wdata;        // only one word per write
    end
  end

  // addressed line, read combinationally
  assign line_tag   = tags[index];
  assign line_word0 = data[index][0];
  assign line_word1 = data[index][1];
  assign line_valid = valid[index];
  assign line_dirty = dirty[index];

  // tag compare against a valid entry
  assign hit = line_valid && (line_tag == tag);

endmodule

// ==== hw/mem_bus_pkg.sv ====
// data side definitions shared by the cache and the memory model
package mem_bus_pkg;

  // width of one data word on both the processor and memory side
  localparam int WORD_W = 32;

  // one data word
  typedef logic [WORD_W-1:0] word_t;

  // a cache line moves as this many single-word transfers
  // fill and writeback each issue one request per word,
  // each held steady until a cycle with dwait low
  localparam int WORDS_PER_LINE = 2;

  // memory side handshake, for reference
  //   dREN / dWEN with daddr (and dstore on a write) held until !dwait
  //   dload valid in the !dwait cycle of a read
  //   only one of dREN / dWEN is high at a time

endpackage

// ==== hw/cache_geom_pkg.sv ====
// geometry of the data cache as seen from the byte address
// address layout, msb first: tag | index | word select | byte offset
package cache_geom_pkg;

  // byte address as issued by the processor
  localparam int ADDR_W = 32;

  // words are 4 bytes, low two bits always zero on the bus
  localparam int BYTE_OFF_W = 2;

  // two words per line -> one select bit
  localparam int WORD_SEL_W = 1;

  // default set count, top level may override
  localparam int DEF_SETS = 8;

  // final store after a flush carries the hit count here
  localparam logic [ADDR_W-1:0] HIT_COUNT_ADDR = 32'h0000_3100;

  // index bits needed for a given set count
  // a single set still gets one bit so the vectors stay legal
  function automatic int index_bits(input int sets);
    int bits;
    bits = $clog2(sets);
    if (bits < 1) begin
      bits = 1;
    end
    return bits;
  endfunction

  // tag width then follows as
  //   ADDR_W - index_bits(SETS) - WORD_SEL_W - BYTE_OFF_W
  // 26 bits for the default of 8 sets

endpackage
